/* Makefile */
# Verilator simulation of the IR board

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -f irBoard.f --top-module irBoardTb -Mdir obj_dir
	./obj_dir/VirBoardTb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* irBoard.f */
src/irPkg.sv
src/instrReg.sv
src/dispatchAddr.sv
src/dispatchRam.sv
src/skipTest.sv
src/diagReadMux.sv
src/irBoard.sv
testbench/irBoardTb.sv

/* src/diagReadMux.sv */
`timescale 1ns/1ps

module diagReadMux (
  input  logic                            diagRead,
  input  irPkg::diagSelT                  diagSel,
  input  logic [0:2]                      norm,
  input  logic [0:irPkg::dramAddrWidth-1] dramAddr,
  input  logic                            enIoJrst,
  input  logic                            enAc,
  input  logic [0:irPkg::acWidth-1]       ac,
  input  logic [0:2]                      dramA,
  input  logic [0:2]                      dramB,
  input  logic [0:7]                      dramJ,
  input  logic                            parityBit,
  input  logic                            testSatisfied,
  input  logic                            jrst0,
  input  logic                            adEq0,
  input  logic                            ioLegal,
  input  logic                            adCryOut,
  output logic [0:irPkg::ebusWidth-1]     ebusData,
  output logic                            ebusDrive,
  output logic                            dramOddParity
);
  import irPkg::*;

  // Covers the J low field as presented after JRST substitution
  assign dramOddParity = ^{dramA, dramB, parityBit, dramJ};

  assign ebusDrive = diagRead;

  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (diagSel)
        sel0:    ebusData = {norm, dramAddr[0:2]};
        sel1:    ebusData = dramAddr[3:8];
        sel2:    ebusData = {enIoJrst, enAc, ac};
        sel3:    ebusData = {dramA, dramB};
        sel4:    ebusData = {testSatisfied, jrst0, dramJ[0:3]};
        sel5:    ebusData = {parityBit, dramOddParity, dramJ[4:7]};
        sel6:    ebusData = {adEq0, ioLegal, adCryOut, 3'b000};
        sel7:    ebusData = '0;
        default: ebusData = '0;
      endcase
    end
  end

endmodule

/* src/dispatchAddr.sv */
`timescale 1ns/1ps

module dispatchAddr (
  input  logic                            CON,
  input  logic                            rstN,
  input  logic                            loadDram,
  input  logic [0:irPkg::irWidth-1]       ir,
  input  logic                            enIoJrst,
  output logic [0:irPkg::dramAddrWidth-1] dramAddr
);

  logic       instr7xx;
  logic       instr3to6;
  logic [0:8] addrNext;

  // In/out instructions are opcodes 7xx
  assign instr7xx  = enIoJrst & (&ir[0:2]);
  assign instr3to6 = &ir[3:6];

  always_comb begin
    if (instr7xx) begin
      // Fold device code region, AC becomes the low bits
      addrNext = {3'b111, ir[7:9] | {3{instr3to6}}, ir[10:12]};
    end else begin
      addrNext = ir[0:8];
    end
  end

  always_ff @(posedge CON) begin
    if (!rstN) begin
      dramAddr <= '0;
    end else if (loadDram) begin
      dramAddr <= addrNext;
    end
  end

  // A lookup must present a clean address to the RAM read edge
  assert property (@(posedge CON) disable iff (!rstN) loadDram |=> !$isunknown(dramAddr))
    else $error("dispatch address unknown after loadDram");

endmodule

/* src/dispatchRam.sv */
`timescale 1ns/1ps

module dispatchRam (
  input  logic                            CON,
  input  logic                            rstN,
  input  logic [0:irPkg::dramAddrWidth-1] dramAddr,
  input  logic [0:irPkg::irWidth-1]       ir,
  input  logic                            isJrst,
  input  logic                            diagLoad,
  input  irPkg::diagFuncT                 diagFunc,
  input  logic [0:irPkg::ebusWidth-1]     ebusIn,
  output logic [0:2]                      dramA,
  output logic [0:2]                      dramB,
  output logic [0:7]                      dramJ,
  output logic                            parityBit
);
  import irPkg::*;

  dramWordT mem [dramDepth];
  dramWordT wrWord;
  dramWordT ramOut;
  logic     ramWrite;

  assign ramWrite = diagLoad &&
                    (diagFunc == fnDramAB || diagFunc == fnDramJHi || diagFunc == fnDramJLo);

  // Field write merges into the currently stored word
  always_comb begin
    wrWord = mem[dramAddr];
    case (diagFunc)
      fnDramAB: begin
        wrWord.dramA = ebusIn[0:2];
        wrWord.dramB = ebusIn[3:5];
      end
      fnDramJHi: begin
        wrWord.parity = ebusIn[1];
        wrWord.jHi    = ebusIn[2:5];
      end
      fnDramJLo: begin
        wrWord.jLo = ebusIn[2:5];
      end
      default: begin
        wrWord = mem[dramAddr];
      end
    endcase
  end

  always_ff @(posedge CON) begin
    if (ramWrite) begin
      mem[dramAddr] <= wrWord;
    end
  end

  // Read register follows the address register by one edge
  always_ff @(posedge CON) begin
    if (!rstN) begin
      ramOut <= '0;
    end else begin
      ramOut <= mem[dramAddr];
    end
  end

  assign dramA     = ramOut.dramA;
  assign dramB     = ramOut.dramB;
  assign parityBit = ramOut.parity;

  // JRST takes its J low bits from the AC field
  assign dramJ = {ramOut.jHi, isJrst ? ir[9:12] : ramOut.jLo};

  // Writes need a defined address from dispatchAddr and defined bus data
  assert property (@(posedge CON) disable iff (!rstN)
                   ramWrite |-> !$isunknown({dramAddr, ebusIn}))
    else $error("dispatch RAM write with unknown address or data");

endmodule

/* src/instrReg.sv */
`timescale 1ns/1ps

module instrReg (
  input  logic                        CON,
  input  logic                        rstN,
  input  logic                        loadIr,
  input  logic                        mbXfer,
  input  logic [0:irPkg::irWidth-1]   adData,
  input  logic [0:irPkg::irWidth-1]   cacheData,
  input  logic                        diagLoad,
  input  irPkg::diagFuncT             diagFunc,
  input  logic [0:irPkg::ebusWidth-1] ebusIn,
  output logic [0:irPkg::irWidth-1]   ir,
  output logic [0:irPkg::acWidth-1]   ac,
  output logic                        enIoJrst,
  output logic                        enAc,
  output logic                        isJrst,
  output logic                        jrst0,
  output logic                        ioLegal
);
  import irPkg::*;

  logic [0:irWidth-1] irNext;

  // Memory buffer path or cache
  assign irNext = mbXfer ? adData : cacheData;

  always_ff @(posedge CON) begin
    if (!rstN) begin
      ir <= '0;
      ac <= '0;
    end else if (loadIr) begin
      ir <= irNext;
      // AC field taken from the incoming word, not the old ir
      ac <= enAc ? irNext[9:12] : '0;
    end
  end

  // Enable flags only change under diagnostic control
  always_ff @(posedge CON) begin
    if (!rstN) begin
      enIoJrst <= 1'b0;
      enAc     <= 1'b0;
    end else if (diagLoad && diagFunc == fnEnables) begin
      enIoJrst <= ebusIn[0];
      enAc     <= ebusIn[1];
    end
  end

  // Opcode decodes
  assign isJrst  = (ir[0:8] == jrstOpcode);
  assign jrst0   = isJrst && (ir[9:12] == '0);
  assign ioLegal = &ir[3:6];

  // Instruction loads and diagnostic loads come from different phases
  assert property (@(posedge CON) disable iff (!rstN) !(loadIr && diagLoad))
    else $error("loadIr and diagLoad asserted together");

endmodule

/* src/irBoard.sv */
`timescale 1ns/1ps

module irBoard (
  input  logic                        CON,
  input  logic                        rstN,
  input  logic                        loadIr,
  input  logic                        mbXfer,
  input  logic [0:irPkg::adWidth-1]   adData,
  input  logic [0:irPkg::irWidth-1]   cacheData,
  input  logic                        adCryOut,
  input  logic                        loadDram,
  input  logic [7:8]                  magic,
  input  logic                        diagLoad,
  input  irPkg::diagFuncT             diagFunc,
  input  logic                        diagRead,
  input  irPkg::diagSelT              diagSel,
  input  logic [0:irPkg::ebusWidth-1] ebusIn,
  output logic [0:irPkg::irWidth-1]   ir,
  output logic [0:irPkg::acWidth-1]   ac,
  output logic                        jrst0,
  output logic                        ioLegal,
  output logic [0:2]                  dramA,
  output logic [0:2]                  dramB,
  output logic [0:7]                  dramJ,
  output logic                        testSatisfied,
  output logic                        adEq0,
  output logic [0:2]                  norm,
  output logic                        dramOddParity,
  output logic [0:irPkg::ebusWidth-1] ebusData,
  output logic                        ebusDrive
);
  import irPkg::*;

  logic                     enIoJrst;
  logic                     enAc;
  logic                     isJrst;
  logic                     parityBit;
  logic [0:dramAddrWidth-1] dramAddr;

  // Only the top 13 adder bits reach the IR
  instrReg u_instrReg (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer),
    .adData(adData[0:irWidth-1]), .cacheData(cacheData),
    .diagLoad(diagLoad), .diagFunc(diagFunc), .ebusIn(ebusIn),
    .ir(ir), .ac(ac), .enIoJrst(enIoJrst), .enAc(enAc),
    .isJrst(isJrst), .jrst0(jrst0), .ioLegal(ioLegal)
  );

  dispatchAddr u_dispatchAddr (
    .CON(CON), .rstN(rstN), .loadDram(loadDram), .ir(ir),
    .enIoJrst(enIoJrst), .dramAddr(dramAddr)
  );

  dispatchRam u_dispatchRam (
    .CON(CON), .rstN(rstN), .dramAddr(dramAddr), .ir(ir), .isJrst(isJrst),
    .diagLoad(diagLoad), .diagFunc(diagFunc), .ebusIn(ebusIn),
    .dramA(dramA), .dramB(dramB), .dramJ(dramJ), .parityBit(parityBit)
  );

  skipTest u_skipTest (
    .adData(adData), .adCryOut(adCryOut), .magic(magic), .dramB(dramB),
    .testSatisfied(testSatisfied), .adEq0(adEq0), .norm(norm)
  );

  diagReadMux u_diagReadMux (
    .diagRead(diagRead), .diagSel(diagSel), .norm(norm), .dramAddr(dramAddr),
    .enIoJrst(enIoJrst), .enAc(enAc), .ac(ac),
    .dramA(dramA), .dramB(dramB), .dramJ(dramJ), .parityBit(parityBit),
    .testSatisfied(testSatisfied), .jrst0(jrst0), .adEq0(adEq0),
    .ioLegal(ioLegal), .adCryOut(adCryOut),
    .ebusData(ebusData), .ebusDrive(ebusDrive), .dramOddParity(dramOddParity)
  );

endmodule

/* src/irPkg.sv */
package irPkg;

  // Instruction field is opcode 0-8 then AC 9-12, bit 0 is the MSB
  localparam int irWidth = 13;
  localparam int acWidth = 4;

  // Adder result from the data-path board
  localparam int adWidth = 36;

  // Dispatch RAM geometry
  localparam int dramAddrWidth = 9;
  localparam int dramDepth = 512;

  // Diagnostic bus slice owned by this board
  localparam int ebusWidth = 6;

  // JRST, jump and restore
  localparam logic [0:8] jrstOpcode = 9'o254;

  // One dispatch RAM word, 15 bits
  typedef struct packed {
    logic [0:2]  dramA;
    logic [0:2]  dramB;
    logic        parity;
    logic [1:4]  jHi;
    logic [7:10] jLo;
  } dramWordT;

  // Diagnostic load functions decoded by this board
  typedef enum logic [2:0] {
    fnDramAB  = 3'o0,
    fnDramJHi = 3'o2,
    fnDramJLo = 3'o3,
    fnEnables = 3'o5
  } diagFuncT;

  // Diagnostic readout groups
  typedef enum logic [2:0] {
    sel0 = 3'd0,
    sel1 = 3'd1,
    sel2 = 3'd2,
    sel3 = 3'd3,
    sel4 = 3'd4,
    sel5 = 3'd5,
    sel6 = 3'd6,
    sel7 = 3'd7
  } diagSelT;

endpackage

/* src/skipTest.sv */
`timescale 1ns/1ps

module skipTest (
  input  logic [0:irPkg::adWidth-1] adData,
  input  logic                      adCryOut,
  input  logic [7:8]                magic,
  input  logic [0:2]                dramB,
  output logic                      testSatisfied,
  output logic                      adEq0,
  output logic [0:2]                norm
);

  logic gt;
  logic magicEq;
  logic anyTerm;

  assign adEq0   = ~|adData;
  assign gt      = adData[0] ^ adCryOut;
  assign magicEq = ~(magic[7] ^ magic[8]);

  // EQ, GT, LT and carry terms
  assign anyTerm = (dramB[1] & adEq0) |
                   (dramB[2] & gt & magic[7]) |
                   (dramB[2] & adData[0] & magic[8]) |
                   (magicEq & adCryOut);

  // B bit 0 inverts the sense of the test
  assign testSatisfied = anyTerm ^ dramB[0];

  // Normalize priority, most significant bit wins
  always_comb begin
    if (adData[0]) begin
      norm = 3'd1;
    end else if (|adData[1:6]) begin
      norm = 3'd2;
    end else if (adData[7]) begin
      norm = 3'd3;
    end else if (adData[8]) begin
      norm = 3'd4;
    end else if (adData[9]) begin
      norm = 3'd5;
    end else if (adData[10]) begin
      norm = 3'd6;
    end else if (|adData[11:35]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

/* testbench/irBoardTb.sv */
`timescale 1ns/1ps

module irBoardTb;
  import irPkg::*;

  logic                   CON;
  logic                   rstN;
  logic                   loadIr;
  logic                   mbXfer;
  logic [0:adWidth-1]     adData;
  logic [0:irWidth-1]     cacheData;
  logic                   adCryOut;
  logic                   loadDram;
  logic [7:8]             magic;
  logic                   diagLoad;
  diagFuncT               diagFunc;
  logic                   diagRead;
  diagSelT                diagSel;
  logic [0:ebusWidth-1]   ebusIn;
  logic [0:irWidth-1]     ir;
  logic [0:acWidth-1]     ac;
  logic                   jrst0;
  logic                   ioLegal;
  logic [0:2]             dramA;
  logic [0:2]             dramB;
  logic [0:7]             dramJ;
  logic                   testSatisfied;
  logic                   adEq0;
  logic [0:2]             norm;
  logic                   dramOddParity;
  logic [0:ebusWidth-1]   ebusData;
  logic                   ebusDrive;

  // Reference model state
  dramWordT               memModel [dramDepth];
  logic [0:irWidth-1]     irExp;
  logic [0:acWidth-1]     acExp;
  logic [0:dramAddrWidth-1] addrModel;
  logic                   enIoModel;
  logic                   enAcModel;
  logic [0:adWidth-1]     adModel;
  logic                   cryModel;
  logic [7:8]             magicModel;
  logic [0:irWidth-1]     entIr [6];
  logic                   entIo [6];

  int seed = 54901;
  int errors = 0;
  int testStartErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;

  irBoard u_irBoard (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer), .adData(adData),
    .cacheData(cacheData), .adCryOut(adCryOut), .loadDram(loadDram), .magic(magic),
    .diagLoad(diagLoad), .diagFunc(diagFunc), .diagRead(diagRead), .diagSel(diagSel),
    .ebusIn(ebusIn), .ir(ir), .ac(ac), .jrst0(jrst0), .ioLegal(ioLegal),
    .dramA(dramA), .dramB(dramB), .dramJ(dramJ), .testSatisfied(testSatisfied),
    .adEq0(adEq0), .norm(norm), .dramOddParity(dramOddParity),
    .ebusData(ebusData), .ebusDrive(ebusDrive)
  );

  initial CON = 1'b0;
  always #5 CON = ~CON;

  function automatic logic [31:0] nextRand();
    nextRand = $random(seed);
  endfunction

  function automatic dramWordT randomWord();
    logic [31:0] r;
    r = nextRand();
    randomWord = r[14:0];
  endfunction

  // In/out opcodes 7xx fold into their own dispatch region
  function automatic logic [0:8] modelAddr(input logic [0:12] i, input logic io);
    if (io && i[0:2] == 3'b111) begin
      modelAddr = {3'b111, i[7:9] | {3{i[3:6] == 4'b1111}}, i[10:12]};
    end else begin
      modelAddr = i[0:8];
    end
  endfunction

  function automatic logic skipModel(input logic [0:35] a, input logic cry,
                                     input logic [7:8] mg, input logic [0:2] b);
    logic gt;
    logic term;
    gt = a[0] ^ cry;
    term = (b[1] & (a == '0)) | (b[2] & gt & mg[7]) | (b[2] & a[0] & mg[8]) |
           ((mg[7] == mg[8]) & cry);
    skipModel = b[0] ^ term;
  endfunction

  function automatic logic [0:2] normModel(input logic [0:35] a);
    if (a[0]) return 3'd1;
    else if (|a[1:6]) return 3'd2;
    else if (a[7]) return 3'd3;
    else if (a[8]) return 3'd4;
    else if (a[9]) return 3'd5;
    else if (a[10]) return 3'd6;
    else if (|a[11:35]) return 3'd7;
    return 3'd0;
  endfunction

  // Stored word as presented with JRST taking J low from the AC field
  function automatic dramWordT presentedWord(input logic [0:8] addr);
    presentedWord = memModel[addr];
    if (irExp[0:8] == jrstOpcode) presentedWord.jLo = irExp[9:12];
  endfunction

  function automatic logic [0:5] expectedEbus(input int s);
    dramWordT w;
    logic     isJrst0;
    w = presentedWord(addrModel);
    isJrst0 = (irExp == {jrstOpcode, 4'h0});
    case (s)
      0: expectedEbus = {normModel(adModel), addrModel[0:2]};
      1: expectedEbus = addrModel[3:8];
      2: expectedEbus = {enIoModel, enAcModel, acExp};
      3: expectedEbus = {w.dramA, w.dramB};
      4: expectedEbus = {skipModel(adModel, cryModel, magicModel, w.dramB), isJrst0, w.jHi};
      5: expectedEbus = {w.parity, ^w, w.jLo};
      6: expectedEbus = {adModel == '0, &irExp[3:6], cryModel, 3'b000};
      default: expectedEbus = '0;
    endcase
  endfunction

  task automatic checkIr(input string name, input logic [0:irWidth-1] got,
                         input logic [0:irWidth-1] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkAc(input string name, input logic [0:acWidth-1] got,
                         input logic [0:acWidth-1] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkWord(input string name, input dramWordT got, input dramWordT exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkNorm(input string name, input logic [0:2] got, input logic [0:2] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkEbus(input string name, input logic [0:ebusWidth-1] got,
                           input logic [0:ebusWidth-1] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic waitCycles(input int n);
    int count;
    count = 0;
    while (count < n) begin
      @(posedge CON);
      count++;
    end
  endtask

  task automatic setEnables(input logic io, input logic acOn);
    logic [31:0] r;
    r = nextRand();
    @(posedge CON);
    diagLoad <= 1'b1;
    diagFunc <= fnEnables;
    ebusIn   <= {io, acOn, r[3:0]};
    @(posedge CON);
    diagLoad <= 1'b0;
    enIoModel = io;
    enAcModel = acOn;
  endtask

  // The unused source carries noise so the mux select matters
  task automatic loadInstr(input logic fromMb, input logic [0:irWidth-1] value);
    logic [31:0] r;
    r = nextRand();
    @(posedge CON);
    mbXfer    <= fromMb;
    adData    <= fromMb ? {value, r[22:0]} : {r[12:0], r[22:0]};
    cacheData <= fromMb ? r[31:19] : value;
    loadIr    <= 1'b1;
    @(posedge CON);
    loadIr <= 1'b0;
    irExp = value;
    acExp = enAcModel ? value[9:12] : '0;
  endtask

  task automatic lookupAddr();
    @(posedge CON);
    loadDram <= 1'b1;
    @(posedge CON);
    loadDram <= 1'b0;
    addrModel = modelAddr(irExp, enIoModel);
  endtask

  task automatic writeWord(input dramWordT w);
    logic [31:0] r;
    r = nextRand();
    @(posedge CON);
    diagLoad <= 1'b1;
    diagFunc <= fnDramAB;
    ebusIn   <= {w.dramA, w.dramB};
    @(posedge CON);
    diagFunc <= fnDramJHi;
    ebusIn   <= {r[0], w.parity, w.jHi};
    @(posedge CON);
    diagFunc <= fnDramJLo;
    ebusIn   <= {r[2:1], w.jLo};
    @(posedge CON);
    diagLoad <= 1'b0;
    memModel[addrModel] = w;
  endtask

  // Stored parity is recovered from the odd-parity output
  task automatic checkDispatch(input logic [0:8] addr);
    dramWordT got;
    dramWordT exp;
    exp = presentedWord(addr);
    got = {dramA, dramB, dramOddParity ^ (^{dramA, dramB, dramJ}), dramJ};
    checkWord("dispatch word", got, exp);
    checkBit("dramOddParity", dramOddParity, ^exp);
  endtask

  task automatic readWord();
    waitCycles(1);
    @(negedge CON);
    checkDispatch(addrModel);
  endtask

  task automatic applyAdder(input logic [0:35] a, input logic cry, input logic [7:8] mg);
    @(posedge CON);
    adData   <= a;
    adCryOut <= cry;
    magic    <= mg;
    adModel    = a;
    cryModel   = cry;
    magicModel = mg;
    @(negedge CON);
  endtask

  // Two lookups in flight with J low following the newest ir
  task automatic backToBack(input logic [0:12] first, input logic [0:12] second);
    logic [0:8] addrFirst;
    logic [0:8] addrSecond;
    addrFirst  = modelAddr(first, enIoModel);
    addrSecond = modelAddr(second, enIoModel);
    @(posedge CON);
    mbXfer    <= 1'b0;
    cacheData <= first;
    loadIr    <= 1'b1;
    @(posedge CON);
    cacheData <= second;
    loadDram  <= 1'b1;
    @(posedge CON);
    loadIr <= 1'b0;
    @(posedge CON);
    loadDram <= 1'b0;
    irExp     = second;
    acExp     = enAcModel ? second[9:12] : '0;
    addrModel = addrSecond;
    @(negedge CON);
    checkDispatch(addrFirst);
    @(posedge CON);
    @(negedge CON);
    checkDispatch(addrSecond);
  endtask

  task automatic startTest();
    testStartErrors = errors;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errors > testStartErrors) begin
      testsFailed++;
      $display("test %0d %s: FAIL, %0d errors", testsRun, name, errors - testStartErrors);
    end else begin
      $display("test %0d %s: PASS", testsRun, name);
    end
  endtask

  task automatic testInstrLoad();
    logic [31:0] r;
    startTest();
    waitCycles(1);
    @(negedge CON);
    checkIr("ir after reset", ir, '0);
    checkAc("ac after reset", ac, '0);
    checkBit("ebusDrive after reset", ebusDrive, 1'b0);
    for (int i = 0; i < 10; i++) begin
      r = nextRand();
      if (i % 3 == 0) setEnables(1'b0, r[20]);
      loadInstr(r[16], r[12:0]);
      @(negedge CON);
      checkIr("ir", ir, irExp);
      checkAc("ac", ac, acExp);
    end
    finishTest("instruction load");
  endtask

  task automatic testDispatch();
    logic [31:0] r;
    logic [0:12] v;
    startTest();
    for (int k = 0; k < 6; k++) begin
      r = nextRand();
      v = r[12:0];
      if (k >= 2) v[0:2] = 3'b111;
      if (k == 3 || k == 4) v[3:6] = 4'b1111;
      entIr[k] = v;
      entIo[k] = (k % 2 == 1);
      setEnables(entIo[k], r[14]);
      loadInstr(r[13], v);
      lookupAddr();
      writeWord(randomWord());
    end
    for (int k = 0; k < 6; k++) begin
      setEnables(entIo[k], 1'b0);
      loadInstr(1'b0, entIr[k]);
      lookupAddr();
      readWord();
      // In/out legal when the device field is all ones
      checkBit("ioLegal", ioLegal, entIr[k][3:6] == 4'b1111);
    end
    setEnables(1'b0, 1'b1);
    backToBack(entIr[0], entIr[2]);
    backToBack(entIr[4], entIr[0]);
    finishTest("dispatch lookup");
  endtask

  task automatic testJrst();
    logic [0:3] acList [5];
    startTest();
    acList = '{4'h0, 4'h5, 4'hf, 4'h1, 4'h0};
    setEnables(1'b0, 1'b1);
    loadInstr(1'b1, {jrstOpcode, 4'h0});
    lookupAddr();
    writeWord(randomWord());
    for (int i = 0; i < 5; i++) begin
      loadInstr(i[0], {jrstOpcode, acList[i]});
      lookupAddr();
      readWord();
      checkBit("jrst0", jrst0, acList[i] == 4'h0);
      checkAc("ac", ac, acList[i]);
    end
    finishTest("jump and restore");
  endtask

  task automatic testSkip();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [0:8]  opc;
    dramWordT    w;
    logic [0:35] a;
    startTest();
    setEnables(1'b0, 1'b0);
    for (int b = 0; b < 8; b++) begin
      opc = 9'o100;
      opc[6:8] = b[2:0];
      loadInstr(1'b0, {opc, 4'h0});
      lookupAddr();
      w = randomWord();
      w.dramB = b[2:0];
      writeWord(w);
      readWord();
      for (int j = 0; j < 6; j++) begin
        r1 = nextRand();
        r2 = nextRand();
        a  = (j == 0) ? '0 : {r1[3:0], r2};
        applyAdder(a, r1[4], r1[6:5]);
        checkBit("testSatisfied", testSatisfied, skipModel(a, r1[4], r1[6:5], b[2:0]));
        checkBit("adEq0", adEq0, a == '0);
      end
    end
    finishTest("skip test");
  endtask

  task automatic testNormParity();
    logic [0:35] a;
    startTest();
    for (int p = 0; p < 36; p++) begin
      a = '0;
      a[p] = 1'b1;
      applyAdder(a, 1'b0, 2'b00);
      checkNorm("norm", norm, normModel(a));
    end
    applyAdder('0, 1'b1, 2'b11);
    checkNorm("norm", norm, 3'd0);
    for (int k = 0; k < 6; k++) begin
      setEnables(entIo[k], 1'b1);
      loadInstr(1'b1, entIr[k]);
      lookupAddr();
      readWord();
    end
    finishTest("normalize and parity");
  endtask

  task automatic testReadout();
    logic [31:0] r1;
    logic [31:0] r2;
    startTest();
    r1 = nextRand();
    r2 = nextRand();
    setEnables(entIo[1], 1'b1);
    loadInstr(1'b1, entIr[1]);
    lookupAddr();
    readWord();
    applyAdder({r1[3:0], r2}, r1[4], r1[6:5]);
    for (int pass = 0; pass < 2; pass++) begin
      for (int s = 0; s < 8; s++) begin
        @(posedge CON);
        diagRead <= (pass == 0);
        diagSel  <= diagSelT'(s[2:0]);
        @(negedge CON);
        checkEbus("ebusData", ebusData, (pass == 0) ? expectedEbus(s) : 6'b000000);
        checkBit("ebusDrive", ebusDrive, pass == 0);
      end
    end
    finishTest("diagnostic readout");
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 20000) begin
      @(posedge CON);
      cycles++;
    end
    $display("Simulation timed out before the test sequence completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rstN      = 1'b0;
    loadIr    = 1'b0;
    mbXfer    = 1'b0;
    adData    = '0;
    cacheData = '0;
    adCryOut  = 1'b0;
    loadDram  = 1'b0;
    magic     = 2'b00;
    diagLoad  = 1'b0;
    diagFunc  = fnDramAB;
    diagRead  = 1'b0;
    diagSel   = sel0;
    ebusIn    = '0;
    enIoModel = 1'b0;
    enAcModel = 1'b0;
    waitCycles(4);
    rstN <= 1'b1;
    testInstrLoad();
    testDispatch();
    testJrst();
    testSkip();
    testNormParity();
    testReadout();
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0 && testsFailed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
